// ==== hw/chachaPkg.sv ====
// ChaCha20 core package: word and state types, sizes, rotate amounts, step and quarter enums
package chachaPkg;

    localparam int unsigned WordWidth  = 32;
    localparam int unsigned StateWords = 16;

    localparam int DefaultDoubleRounds = 10;
    localparam int DefaultCountWidth   = 8;

    typedef logic [WordWidth-1:0] chachaWord;

    // word i lives at row i/4, column i%4
    typedef chachaWord [StateWords-1:0] chachaState;

    // rotate-left amounts, in the order they appear inside a quarter round
    localparam int unsigned RotA = 16;
    localparam int unsigned RotB = 12;
    localparam int unsigned RotC = 8;
    localparam int unsigned RotD = 7;

    // serial ARX steps, one operation per clock
    typedef enum logic [3:0] {
        QrIdle,
        AddAB1, XorDA1, RotD1, AddCD1, XorBC1, RotB1,
        AddAB2, XorDA2, RotD2, AddCD2, XorBC2, RotB2
    } qrStep;

    // bit 2 set means a diagonal quarter
    typedef enum logic [2:0] {
        Col0, Col1, Col2, Col3,
        Diag0, Diag1, Diag2, Diag3
    } quarterSel;

    function automatic chachaWord rotl(chachaWord w, int unsigned n);
        return (w << n) | (w >> (WordWidth - n));
    endfunction

    // state index of lane 0..3 (a, b, c, d) for a quarter selector
    function automatic int unsigned quarterIndex(quarterSel sel, int unsigned lane);
        int unsigned k;
        k = int'(sel[1:0]);
        if (sel[2])
            return lane * 4 + (k + lane) % 4;
        return lane * 4 + k;
    endfunction

endpackage

// ==== hw/qrBus.sv ====
// Quarter-round operand and result bus between state matrix, sequencer and ARX unit
`timescale 1ns/1ps

interface qrBus;
    import chachaPkg::*;

    // operands, valid while qrStart is high
    chachaWord opA, opB, opC, opD;

    // results, held from qrDone until the next qrStart
    chachaWord resA, resB, resC, resD;

    logic qrStart;
    logic qrDone;

    modport matrix (
        output opA, opB, opC, opD,
        input  resA, resB, resC, resD
    );

    modport sequencer (
        output qrStart,
        input  qrDone
    );

    modport unit (
        input  opA, opB, opC, opD, qrStart,
        output resA, resB, resC, resD, qrDone
    );

endinterface

// ==== hw/quarterRoundUnit.sv ====
// Serial ARX quarter-round engine, one add, xor or rotate per clock
`timescale 1ns/1ps

module quarterRoundUnit (
    input logic clk,
    input logic rstN,
    qrBus.unit  bus
);
    import chachaPkg::*;

    qrStep     step;
    chachaWord a, b, c, d;

    ////////////////////////////////////////////////////////////////////////////
    // step sequence
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            step <= QrIdle;
        end else if (bus.qrStart) begin
            step <= AddAB1;
        end else if (step == RotB2) begin
            step <= QrIdle;
        end else if (step != QrIdle) begin
            step <= qrStep'(step + 4'd1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // word registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (bus.qrStart) begin
            a <= bus.opA;
            b <= bus.opB;
            c <= bus.opC;
            d <= bus.opD;
        end else begin
            case (step)
                AddAB1, AddAB2: a <= a + b;
                XorDA1, XorDA2: d <= d ^ a;
                AddCD1, AddCD2: c <= c + d;
                XorBC1, XorBC2: b <= b ^ c;
                RotD1:          d <= rotl(d, RotA);
                RotB1:          b <= rotl(b, RotB);
                RotD2:          d <= rotl(d, RotC);
                RotB2:          b <= rotl(b, RotD);
                default: begin
                    // hold between quarter rounds
                end
            endcase
        end
    end

    // high during the last operation so the results settle one cycle later
    assign bus.qrDone = (step == RotB2);

    assign bus.resA = a;
    assign bus.resB = b;
    assign bus.resC = c;
    assign bus.resD = d;

    // the sequencer only issues to an idle unit
    assert property (@(posedge clk) disable iff (!rstN)
        bus.qrStart |-> step == QrIdle);

    // a finished quarter round leaves the unit idle while the results are written back
    assert property (@(posedge clk) disable iff (!rstN)
        bus.qrDone |=> step == QrIdle && !bus.qrStart);

endmodule

// ==== hw/roundSequencer.sv ====
// Quarter and double-round tracker driving load, issue, writeback and finish
`timescale 1ns/1ps

module roundSequencer #(
    parameter int DoubleRounds = chachaPkg::DefaultDoubleRounds,
    parameter int CountWidth   = chachaPkg::DefaultCountWidth
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 start,
    qrBus.sequencer              bus,
    output logic                 load,
    output logic                 writeBack,
    output logic                 finish,
    output logic                 busy,
    output chachaPkg::quarterSel sel,
    output logic [CountWidth-1:0] blockCount
);
    import chachaPkg::*;

    localparam int RoundWidth = $clog2(DoubleRounds + 1);

    typedef enum logic [2:0] {Idle, Issue, Wait, Write, Finish} seqPhase;

    seqPhase               phase;
    logic [RoundWidth-1:0] roundCnt;
    logic                  lastQuarter;

    assign lastQuarter = (sel == Diag3) && (roundCnt == RoundWidth'(DoubleRounds - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase      <= Idle;
            sel        <= Col0;
            roundCnt   <= '0;
            blockCount <= '0;
        end else begin
            case (phase)
                Idle: begin
                    if (start) begin
                        phase    <= Issue;
                        sel      <= Col0;
                        roundCnt <= '0;
                    end
                end
                Issue: phase <= Wait;
                Wait: begin
                    if (bus.qrDone)
                        phase <= Write;
                end
                Write: begin
                    // Diag3 wraps back to Col0 and closes a double round
                    sel <= quarterSel'(sel + 3'd1);
                    if (sel == Diag3)
                        roundCnt <= roundCnt + 1'b1;
                    phase <= lastQuarter ? Finish : Issue;
                end
                Finish: begin
                    phase      <= Idle;
                    blockCount <= blockCount + 1'b1;
                end
                default: phase <= Idle;
            endcase
        end
    end

    // a start while busy falls outside Idle and is dropped here
    assign load        = (phase == Idle) && start;
    assign bus.qrStart = (phase == Issue);
    assign writeBack   = (phase == Write);
    assign finish      = (phase == Finish);
    assign busy        = (phase != Idle);

    assert property (@(posedge clk) disable iff (!rstN)
        roundCnt <= DoubleRounds);

endmodule

// ==== hw/stateMatrix.sv ====
// Input and working state storage with quarter gather, scatter and feed-forward add
`timescale 1ns/1ps

module stateMatrix (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 load,
    input  logic                 writeBack,
    input  logic                 finish,
    input  chachaPkg::quarterSel sel,
    input  chachaPkg::chachaState stateIn,
    qrBus.matrix                 bus,
    output chachaPkg::chachaState blockOut,
    output logic                 blockReady
);
    import chachaPkg::*;

    chachaState  initState;
    chachaState  workState;
    chachaState  sumState;
    int unsigned idxA, idxB, idxC, idxD;

    ////////////////////////////////////////////////////////////////////////////
    // quarter word selection
    ////////////////////////////////////////////////////////////////////////////

    assign idxA = quarterIndex(sel, 0);
    assign idxB = quarterIndex(sel, 1);
    assign idxC = quarterIndex(sel, 2);
    assign idxD = quarterIndex(sel, 3);

    // gather, operands follow sel continuously
    assign bus.opA = workState[idxA];
    assign bus.opB = workState[idxB];
    assign bus.opC = workState[idxC];
    assign bus.opD = workState[idxD];

    ////////////////////////////////////////////////////////////////////////////
    // state registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (load) begin
            initState <= stateIn;
            workState <= stateIn;
        end else if (writeBack) begin
            // scatter to the same four words the operands came from
            workState[idxA] <= bus.resA;
            workState[idxB] <= bus.resB;
            workState[idxC] <= bus.resC;
            workState[idxD] <= bus.resD;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // feed-forward add and output block
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < StateWords; i++) begin
            sumState[i] = initState[i] + workState[i];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            blockOut   <= '0;
            blockReady <= 1'b0;
        end else begin
            blockReady <= finish;
            // block stays put until the next finish
            if (finish)
                blockOut <= sumState;
        end
    end

endmodule

// ==== hw/chachaBlockCore.sv ====
// ChaCha20 block-function core top level with plain ports
`timescale 1ns/1ps

module chachaBlockCore #(
    parameter int DoubleRounds = chachaPkg::DefaultDoubleRounds,
    parameter int CountWidth   = chachaPkg::DefaultCountWidth
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  start,
    input  chachaPkg::chachaState stateIn,
    output logic                  busy,
    output logic                  blockReady,
    output chachaPkg::chachaState blockOut,
    output logic [CountWidth-1:0] blockCount
);

    chachaPkg::quarterSel sel;
    logic                 load;
    logic                 writeBack;
    logic                 finish;

    // quarter-round operands and results
    qrBus qrIf ();

    quarterRoundUnit quarterRoundUnit_inst (
        .clk  (clk),
        .rstN (rstN),
        .bus  (qrIf.unit)
    );

    roundSequencer #(
        .DoubleRounds (DoubleRounds),
        .CountWidth   (CountWidth)
    ) roundSequencer_inst (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .bus        (qrIf.sequencer),
        .load       (load),
        .writeBack  (writeBack),
        .finish     (finish),
        .busy       (busy),
        .sel        (sel),
        .blockCount (blockCount)
    );

    stateMatrix stateMatrix_inst (
        .clk        (clk),
        .rstN       (rstN),
        .load       (load),
        .writeBack  (writeBack),
        .finish     (finish),
        .sel        (sel),
        .stateIn    (stateIn),
        .bus        (qrIf.matrix),
        .blockOut   (blockOut),
        .blockReady (blockReady)
    );

endmodule

// ==== bench/chachaModel.svh ====
// Reference model of the ChaCha20 quarter round and block function
`ifndef CHACHA_MODEL_SVH
`define CHACHA_MODEL_SVH

function automatic chachaWord rotLeft(chachaWord w, int n);
    return (w << n) | (w >> (32 - n));
endfunction

// one quarter round on the words at ia, ib, ic, id
function automatic chachaState quarterModel(chachaState s, int ia, int ib, int ic, int id);
    chachaWord a;
    chachaWord b;
    chachaWord c;
    chachaWord d;
    a = s[ia];
    b = s[ib];
    c = s[ic];
    d = s[id];
    a = a + b;
    d = rotLeft(d ^ a, 16);
    c = c + d;
    b = rotLeft(b ^ c, 12);
    a = a + b;
    d = rotLeft(d ^ a, 8);
    c = c + d;
    b = rotLeft(b ^ c, 7);
    s[ia] = a;
    s[ib] = b;
    s[ic] = c;
    s[id] = d;
    return s;
endfunction

// columns then diagonals, ten times, then the feed-forward add
function automatic chachaState blockModel(chachaState init);
    chachaState x;
    x = init;
    for (int r = 0; r < DefaultDoubleRounds; r++) begin
        for (int k = 0; k < 4; k++) begin
            x = quarterModel(x, k, 4 + k, 8 + k, 12 + k);
        end
        for (int k = 0; k < 4; k++) begin
            x = quarterModel(x, k, 4 + (k + 1) % 4, 8 + (k + 2) % 4, 12 + (k + 3) % 4);
        end
    end
    for (int i = 0; i < 16; i++) begin
        x[i] = x[i] + init[i];
    end
    return x;
endfunction

`endif

// ==== bench/chachaBlockTb.sv ====
// ChaCha20 block core testbench with stimulus table, clock, reset, checks and reporting
`timescale 1ns/1ps

module chachaBlockTb;
    import chachaPkg::*;

    `include "chachaModel.svh"

    localparam int NumEntries = 4;
    localparam int Timeout    = 2000;

    // RFC 8439 section 2.3.2 input and output with word 0 first
    localparam logic [31:0] RfcIn [16] = '{
        32'h61707865, 32'h3320646e, 32'h79622d32, 32'h6b206574,
        32'h03020100, 32'h07060504, 32'h0b0a0908, 32'h0f0e0d0c,
        32'h13121110, 32'h17161514, 32'h1b1a1918, 32'h1f1e1d1c,
        32'h00000001, 32'h09000000, 32'h4a000000, 32'h00000000};
    localparam logic [31:0] RfcOut [16] = '{
        32'he4e7f110, 32'h15593bd1, 32'h1fdd0f50, 32'hc47120a3,
        32'hc7f4d1c7, 32'h0368c033, 32'h9aaa2204, 32'h4e6cd4c3,
        32'h466482d2, 32'h09aa9f07, 32'h05d7c214, 32'ha2028bd9,
        32'hd19c12b5, 32'hb94e16de, 32'he883d0cb, 32'h4e3c50a2};

    logic                         clk;
    logic                         rstN;
    logic                         start;
    chachaState                   stateIn;
    logic                         busy;
    logic                         blockReady;
    chachaState                   blockOut;
    logic [DefaultCountWidth-1:0] blockCount;

    chachaState tableIn  [NumEntries];
    chachaState tableRef [NumEntries];
    integer     seed;
    int         errors;
    int         tests;
    int         failedTests;

    chachaBlockCore chachaBlockCore_inst (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .stateIn    (stateIn),
        .busy       (busy),
        .blockReady (blockReady),
        .blockOut   (blockOut),
        .blockCount (blockCount)
    );

    always #10 clk = ~clk;

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic checkValue(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail t=%0t %s got %h expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic checkBlock(chachaState expected);
        for (int i = 0; i < StateWords; i++) begin
            checkValue($sformatf("blockOut[%0d]", i), blockOut[i], expected[i]);
        end
    endtask

    function automatic chachaState randomState();
        chachaState s;
        for (int i = 0; i < StateWords; i++) begin
            s[i] = $random(seed);
        end
        return s;
    endfunction

    task automatic pulseStart(chachaState s);
        stateIn = s;
        start   = 1'b1;
        nextCycle();
        start = 1'b0;
    endtask

    // busy stays high until blockReady, which arrives together with busy low
    task automatic waitReady(output bit ok);
        int cycles;
        cycles = 0;
        while (blockReady !== 1'b1 && cycles < Timeout) begin
            checkValue("busy", busy, 1);
            nextCycle();
            cycles++;
        end
        ok = (blockReady === 1'b1);
        if (!ok) begin
            $display("Timeout: no blockReady within %0d cycles of start", Timeout);
            errors++;
        end else begin
            checkValue("busy", busy, 0);
        end
    endtask

    task automatic report(string name, int errorsBefore);
        tests++;
        if (errors == errorsBefore) begin
            $display("test %s: ok", name);
        end else begin
            failedTests++;
            $display("test %s: failed", name);
        end
    endtask

    initial begin
        bit                           ok;
        int                           mark;
        int                           extraReady;
        logic [DefaultCountWidth-1:0] countBefore;
        seed        = 32'hda2c_f560;
        clk         = 1'b0;
        rstN        = 1'b0;
        start       = 1'b0;
        stateIn     = '0;
        errors      = 0;
        tests       = 0;
        failedTests = 0;
        for (int i = 0; i < StateWords; i++) begin
            tableIn[0][i]  = RfcIn[i];
            tableRef[0][i] = RfcOut[i];
        end
        for (int n = 1; n < NumEntries; n++) begin
            tableIn[n]  = randomState();
            tableRef[n] = blockModel(tableIn[n]);
        end
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        nextCycle();

        mark = errors;
        checkValue("busy", busy, 0);
        checkValue("blockReady", blockReady, 0);
        checkValue("blockCount", blockCount, 0);
        report("reset", mark);

        ok = 1'b1;
        for (int n = 0; n < NumEntries && ok; n++) begin
            mark        = errors;
            countBefore = blockCount;
            pulseStart(tableIn[n]);
            waitReady(ok);
            if (ok) begin
                checkBlock(tableRef[n]);
                // the published RFC block is also held against the model
                if (n == 0) begin
                    checkBlock(blockModel(tableIn[0]));
                end
                checkValue("blockCount", blockCount, countBefore + 1'b1);
            end
            report($sformatf("entry %0d", n), mark);
        end

        if (ok) begin
            mark = errors;
            checkValue("blockCount", blockCount, NumEntries);
            report("block count", mark);

            // second start with another state lands while busy
            mark = errors;
            pulseStart(tableIn[1]);
            repeat (5) nextCycle();
            pulseStart(tableIn[2]);
            waitReady(ok);
            if (ok) begin
                checkBlock(tableRef[1]);
                checkValue("blockCount", blockCount, NumEntries + 1);
                extraReady = 0;
                repeat (1200) begin
                    nextCycle();
                    extraReady += blockReady;
                end
                checkValue("blockReady pulses", extraReady, 0);
                checkValue("blockCount", blockCount, NumEntries + 1);
            end
            report("start while busy", mark);
        end

        if (ok) begin
            mark = errors;
            repeat (50) begin
                stateIn = randomState();
                nextCycle();
                checkBlock(tableRef[1]);
            end
            report("output hold", mark);
        end

        $display("tests %0d, failed %0d, errors %0d", tests, failedTests, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== chachaBlockCore.f ====
+incdir+bench
hw/chachaPkg.sv
hw/qrBus.sv
hw/quarterRoundUnit.sv
hw/roundSequencer.sv
hw/stateMatrix.sv
hw/chachaBlockCore.sv
bench/chachaBlockTb.sv

// ==== Makefile ====
SOURCES := $(filter-out +%,$(shell cat chachaBlockCore.f)) bench/chachaModel.svh

.PHONY: run clean

run: obj_dir/VchachaBlockTb
	@out="$$(./obj_dir/VchachaBlockTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

obj_dir/VchachaBlockTb: chachaBlockCore.f $(SOURCES)
	verilator --binary --assert -Wno-fatal -f chachaBlockCore.f --top-module chachaBlockTb

clean:
	rm -rf obj_dir
